/* design/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////////////////

// Base geometry of the system port and the set array
`define CACHE_BYTE_ADDR_BITS  25
`define CACHE_INDEX_BITS      8
`define CACHE_WORDS_PER_LINE  4
`define CACHE_WORD_BITS       32

// Derived widths
`define CACHE_SETS            (1 << `CACHE_INDEX_BITS)
`define CACHE_STRB_BITS       (`CACHE_WORD_BITS / 8)
`define CACHE_WORD_OFF_BITS   $clog2(`CACHE_WORDS_PER_LINE)
`define CACHE_BYTE_OFF_BITS   $clog2(`CACHE_STRB_BITS)
`define CACHE_TAG_BITS        (`CACHE_BYTE_ADDR_BITS - `CACHE_INDEX_BITS \
                               - `CACHE_WORD_OFF_BITS - `CACHE_BYTE_OFF_BITS)
`define CACHE_LINE_BITS       (`CACHE_WORDS_PER_LINE * `CACHE_WORD_BITS)

// One DDR access moves a whole line, so memory is addressed by line
`define CACHE_MEM_ADDR_BITS   (`CACHE_TAG_BITS + `CACHE_INDEX_BITS)

`endif

/* design/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    // Byte address as seen by the cache, MSB first
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]      tag;
        logic [`CACHE_INDEX_BITS-1:0]    index;
        logic [`CACHE_WORD_OFF_BITS-1:0] word;
        logic [`CACHE_BYTE_OFF_BITS-1:0] byte_off;
    } cache_addr_t;

    // System request, all-zero strobes means a read
    typedef struct packed {
        cache_addr_t                 addr;
        logic [`CACHE_WORD_BITS-1:0] wdata;
        logic [`CACHE_STRB_BITS-1:0] wstrb;
    } cache_req_t;

    // Stored line with its status bits
    typedef struct packed {
        logic                        lru;
        logic                        valid;
        logic                        dirty;
        logic [`CACHE_TAG_BITS-1:0]  tag;
        logic [`CACHE_LINE_BITS-1:0] data;
    } cache_line_t;

    // Line-wide DDR request
    typedef struct packed {
        logic [`CACHE_MEM_ADDR_BITS-1:0] addr;
        logic [`CACHE_LINE_BITS-1:0]     wdata;
        logic                            write;
    } mem_req_t;

    // Source of the line written back into a way
    typedef enum logic [1:0] {
        WB_MERGE  = 2'd0,
        WB_REFILL = 2'd1,
        WB_CLEAR  = 2'd2
    } wb_src_e;

endpackage

/* design/cache_way_ram.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_way_ram (
    input  logic                          clk,
    input  logic [`CACHE_INDEX_BITS-1:0]  index,
    input  logic                          we,
    input  cache_pkg::cache_line_t        wr_line,
    output cache_pkg::cache_line_t        rd_line
);

    cache_pkg::cache_line_t lines [`CACHE_SETS];

    ////////////////////////////////////////////////////////////////////////
    // Single port, write-first
    ////////////////////////////////////////////////////////////////////////

    // The set is read on every edge so the output tracks the index.
    // A write shows up on rd_line on the same edge, the write-miss
    // merge relies on seeing the refilled line one cycle later
    always_ff @(posedge clk) begin
        if (we) begin
            lines[index] <= wr_line;
            rd_line      <= wr_line;
        end else begin
            rd_line <= lines[index];
        end
    end

endmodule

/* design/cache_line_update.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_line_update #(
    parameter int WAY_ID = 0
) (
    input  cache_pkg::wb_src_e           mode,
    input  cache_pkg::cache_req_t        req,
    input  cache_pkg::cache_line_t       own_line,
    input  logic                         other_lru,
    input  logic [`CACHE_LINE_BITS-1:0]  mem_rdata,
    output cache_pkg::cache_line_t       new_line
);

    localparam int WORD_BITS = `CACHE_WORD_BITS;
    localparam int STRB_BITS = `CACHE_STRB_BITS;

    ////////////////////////////////////////////////////////////////////////
    // LRU encoding
    ////////////////////////////////////////////////////////////////////////

    // Way 0 is newer when both bits match, way 1 when they differ.
    // To become newest, way 0 copies the other bit and way 1 inverts it
    logic newest_lru;

    assign newest_lru = (WAY_ID == 0) ? other_lru : !other_lru;

    // Strobed bytes overlaid on the addressed word
    logic [`CACHE_LINE_BITS-1:0] merged_data;

    always_comb begin
        merged_data = own_line.data;
        for (int b = 0; b < STRB_BITS; b++) begin
            if (req.wstrb[b]) begin
                merged_data[req.addr.word * WORD_BITS + b * 8 +: 8] = req.wdata[b * 8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Next line select
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (mode)
            cache_pkg::WB_MERGE: begin
                // Read hits also come through here, only valid and LRU move
                new_line       = own_line;
                new_line.data  = merged_data;
                new_line.valid = 1'b1;
                new_line.dirty = own_line.dirty || (req.wstrb != '0);
                new_line.lru   = newest_lru;
            end
            cache_pkg::WB_REFILL: begin
                new_line.lru   = newest_lru;
                new_line.valid = 1'b1;
                new_line.dirty = 1'b0;
                new_line.tag   = req.addr.tag;
                new_line.data  = mem_rdata;
            end
            default: begin
                // Fully zeroed, LRU included, so the sweep leaves a known order
                new_line = '0;
            end
        endcase
    end

endmodule

/* design/cache_lookup.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_lookup (
    input  logic                         clk,
    input  cache_pkg::cache_req_t        req,
    input  cache_pkg::cache_line_t       line_0,
    input  cache_pkg::cache_line_t       line_1,
    output logic                         hit,
    output logic                         hit_way,
    output logic                         victim_way,
    output logic                         victim_dirty,
    output logic [`CACHE_TAG_BITS-1:0]   victim_tag,
    output logic [`CACHE_WORD_BITS-1:0]  hit_word
);

    logic match_0;
    logic match_1;
    logic way_0_newer;
    logic victim_sel;

    cache_pkg::cache_line_t victim_line;
    cache_pkg::cache_line_t hit_line;

    // Tag compare against both ways
    assign match_0 = line_0.valid && (line_0.tag == req.addr.tag);
    assign match_1 = line_1.valid && (line_1.tag == req.addr.tag);

    // Same-or-different LRU rule, victim is the older way
    assign way_0_newer = (line_0.lru == line_1.lru);
    assign victim_sel  = way_0_newer;

    assign victim_line = victim_sel ? line_1 : line_0;
    assign hit_line    = match_0 ? line_0 : line_1;

    ////////////////////////////////////////////////////////////////////////
    // Compare stage register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        hit          <= match_0 || match_1;
        hit_way      <= !match_0;
        victim_way   <= victim_sel;
        victim_dirty <= victim_line.valid && victim_line.dirty;
        victim_tag   <= victim_line.tag;
        hit_word     <= hit_line.data[req.addr.word * `CACHE_WORD_BITS +: `CACHE_WORD_BITS];
    end

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sys_valid,
    input  cache_pkg::cache_req_t         req,
    input  logic                          hit,
    input  logic                          hit_way,
    input  logic                          victim_way,
    input  logic                          victim_dirty,
    input  logic [`CACHE_TAG_BITS-1:0]    victim_tag,
    input  logic [`CACHE_WORD_BITS-1:0]   hit_word,
    input  cache_pkg::cache_line_t        victim_line_0,
    input  cache_pkg::cache_line_t        victim_line_1,
    input  logic [`CACHE_LINE_BITS-1:0]   mem_rdata,
    input  logic                          mem_ready,
    output logic                          sys_ready,
    output logic [`CACHE_WORD_BITS-1:0]   sys_rdata,
    output cache_pkg::mem_req_t           mem_req,
    output logic                          mem_valid,
    output logic                          sweep_active,
    output logic [`CACHE_INDEX_BITS-1:0]  sweep_index,
    output logic                          we_0,
    output logic                          we_1,
    output cache_pkg::wb_src_e            wb_mode
);

    typedef enum logic [3:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK,
        ST_MISS,
        ST_FLUSH,
        ST_FLUSH_WAIT,
        ST_WRITE_APPLY,
        ST_DONE
    } state_e;

    state_e state;

    logic [`CACHE_INDEX_BITS-1:0] sweep_cnt;
    logic                         lookup_wait;   // RAM read and compare take two cycles
    logic                         fill_way;
    logic                         flushed;       // victim already written back and cleared
    logic                         is_write;
    logic [`CACHE_WORD_BITS-1:0]  refill_word;

    assign is_write     = (req.wstrb != '0);
    assign refill_word  = mem_rdata[req.addr.word * `CACHE_WORD_BITS +: `CACHE_WORD_BITS];
    assign sweep_active = (state == ST_SWEEP);
    assign sweep_index  = sweep_cnt;

    ////////////////////////////////////////////////////////////////////////
    // Way write enables, the write lands on the edge that leaves the state
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        we_0    = 1'b0;
        we_1    = 1'b0;
        wb_mode = cache_pkg::WB_MERGE;
        case (state)
            ST_SWEEP: begin
                we_0    = 1'b1;
                we_1    = 1'b1;
                wb_mode = cache_pkg::WB_CLEAR;
            end
            ST_CHECK: begin
                // Read hits rewrite the line to refresh LRU
                we_0 = hit && !hit_way;
                we_1 = hit && hit_way;
            end
            ST_MISS: begin
                we_0    = mem_ready && !fill_way;
                we_1    = mem_ready && fill_way;
                wb_mode = cache_pkg::WB_REFILL;
            end
            ST_FLUSH: begin
                we_0    = mem_ready && !fill_way;
                we_1    = mem_ready && fill_way;
                wb_mode = cache_pkg::WB_CLEAR;
            end
            ST_WRITE_APPLY: begin
                we_0 = !fill_way;
                we_1 = fill_way;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Main FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_SWEEP;
            sweep_cnt   <= '0;
            lookup_wait <= 1'b0;
            fill_way    <= 1'b0;
            flushed     <= 1'b0;
            sys_ready   <= 1'b0;
            mem_valid   <= 1'b0;
        end else begin
            case (state)
                ST_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == '1) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    flushed <= 1'b0;
                    if (sys_valid) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    lookup_wait <= !lookup_wait;
                    if (lookup_wait) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (hit) begin
                        sys_rdata <= hit_word;
                        sys_ready <= 1'b1;
                        state     <= ST_DONE;
                    end else if (!mem_ready) begin
                        mem_valid <= 1'b1;
                        if (victim_dirty && !flushed) begin
                            // Write the victim back first
                            fill_way      <= victim_way;
                            mem_req.addr  <= {victim_tag, req.addr.index};
                            mem_req.wdata <= victim_way ? victim_line_1.data
                                                        : victim_line_0.data;
                            mem_req.write <= 1'b1;
                            state         <= ST_FLUSH;
                        end else begin
                            // After a flush, refill the way that was just freed
                            if (!flushed) begin
                                fill_way <= victim_way;
                            end
                            mem_req.addr  <= {req.addr.tag, req.addr.index};
                            mem_req.write <= 1'b0;
                            state         <= ST_MISS;
                        end
                    end
                end
                ST_MISS: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        if (is_write) begin
                            state <= ST_WRITE_APPLY;
                        end else begin
                            sys_rdata <= refill_word;
                            sys_ready <= 1'b1;
                            state     <= ST_DONE;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        flushed   <= 1'b1;
                        state     <= ST_FLUSH_WAIT;
                    end
                end
                ST_FLUSH_WAIT: begin
                    if (!mem_ready) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_WRITE_APPLY: begin
                    sys_ready <= 1'b1;
                    state     <= ST_DONE;
                end
                ST_DONE: begin
                    if (!sys_valid) begin
                        sys_ready <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* design/ddr_cache.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module ddr_cache (
    input  logic                          clk,
    input  logic                          rst,
    input  cache_pkg::cache_req_t         sys_req,
    input  logic                          sys_valid,
    output logic                          sys_ready,
    output logic [`CACHE_WORD_BITS-1:0]   sys_rdata,
    output cache_pkg::mem_req_t           mem_req,
    output logic                          mem_valid,
    input  logic [`CACHE_LINE_BITS-1:0]   mem_rdata,
    input  logic                          mem_ready
);

    cache_pkg::cache_line_t line_0;
    cache_pkg::cache_line_t line_1;
    cache_pkg::cache_line_t new_line_0;
    cache_pkg::cache_line_t new_line_1;
    cache_pkg::wb_src_e     wb_mode;

    logic                         we_0;
    logic                         we_1;
    logic                         sweep_active;
    logic [`CACHE_INDEX_BITS-1:0] sweep_index;
    logic [`CACHE_INDEX_BITS-1:0] ram_index;

    logic                         hit;
    logic                         hit_way;
    logic                         victim_way;
    logic                         victim_dirty;
    logic [`CACHE_TAG_BITS-1:0]   victim_tag;
    logic [`CACHE_WORD_BITS-1:0]  hit_word;

    // Sweep counter owns the RAM index until the sweep is over
    assign ram_index = sweep_active ? sweep_index : sys_req.addr.index;

    ////////////////////////////////////////////////////////////////////////
    // Lookup, ways and line updaters
    ////////////////////////////////////////////////////////////////////////

    cache_lookup u_lookup (
        .clk          (clk),
        .req          (sys_req),
        .line_0       (line_0),
        .line_1       (line_1),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .hit_word     (hit_word)
    );

    cache_way_ram u_way_0 (
        .clk     (clk),
        .index   (ram_index),
        .we      (we_0),
        .wr_line (new_line_0),
        .rd_line (line_0)
    );

    cache_way_ram u_way_1 (
        .clk     (clk),
        .index   (ram_index),
        .we      (we_1),
        .wr_line (new_line_1),
        .rd_line (line_1)
    );

    cache_line_update #(.WAY_ID(0)) u_update_0 (
        .mode      (wb_mode),
        .req       (sys_req),
        .own_line  (line_0),
        .other_lru (line_1.lru),
        .mem_rdata (mem_rdata),
        .new_line  (new_line_0)
    );

    cache_line_update #(.WAY_ID(1)) u_update_1 (
        .mode      (wb_mode),
        .req       (sys_req),
        .own_line  (line_1),
        .other_lru (line_0.lru),
        .mem_rdata (mem_rdata),
        .new_line  (new_line_1)
    );

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .sys_valid     (sys_valid),
        .req           (sys_req),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .hit_word      (hit_word),
        .victim_line_0 (line_0),
        .victim_line_1 (line_1),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready),
        .sys_ready     (sys_ready),
        .sys_rdata     (sys_rdata),
        .mem_req       (mem_req),
        .mem_valid     (mem_valid),
        .sweep_active  (sweep_active),
        .sweep_index   (sweep_index),
        .we_0          (we_0),
        .we_1          (we_1),
        .wb_mode       (wb_mode)
    );

endmodule

/* verif/ddr_cache_asserts.sv */
`timescale 1ns/1ps

module ddr_cache_asserts (
    input logic                clk,
    input logic                rst,
    input logic                sys_valid,
    input logic                sys_ready,
    input cache_pkg::mem_req_t mem_req,
    input logic                mem_valid,
    input logic                mem_ready
);

    // Request held steady until the memory answers
    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_ready) |=> $stable(mem_req))
        else $error("mem_req changed while waiting for mem_ready");

    // A new memory request only once the last reply has been released
    mem_valid_after_release: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_valid) |-> !$past(mem_ready))
        else $error("mem_valid raised while mem_ready was high");

    sys_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(sys_ready) |-> $past(sys_valid))
        else $error("sys_ready rose without sys_valid");

    // Outputs quiet once reset has been seen
    quiet_in_reset: assert property (@(posedge clk)
        $past(rst) |-> (!mem_valid && !sys_ready))
        else $error("mem_valid or sys_ready high during reset");

endmodule

bind ddr_cache ddr_cache_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .sys_valid (sys_valid),
    .sys_ready (sys_ready),
    .mem_req   (mem_req),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready)
);

/* verif/ddr_cache_tb.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module ddr_cache_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MEM_DELAY      = 3;
    localparam int RANDOM_OPS     = 200;

    logic                            clk;
    logic                            rst;
    cache_pkg::cache_req_t           sys_req;
    logic                            sys_valid;
    logic                            sys_ready;
    logic [`CACHE_WORD_BITS-1:0]     sys_rdata;
    cache_pkg::mem_req_t             mem_req;
    logic                            mem_valid;
    logic [`CACHE_LINE_BITS-1:0]     mem_rdata;
    logic                            mem_ready;

    // Memory model contents by word address, expected contents by byte address
    logic [31:0]                     mem_words [int];
    logic [7:0]                      ref_bytes [int];

    int                              errors;
    int                              mem_faults;
    int                              requests;
    int                              mem_reads;
    int                              mem_writes;
    logic [`CACHE_MEM_ADDR_BITS-1:0] last_wr_addr;
    logic [`CACHE_LINE_BITS-1:0]     last_wr_data;
    logic [31:0]                     rng_state;

    ddr_cache UUT (
        .clk       (clk),
        .rst       (rst),
        .sys_req   (sys_req),
        .sys_valid (sys_valid),
        .sys_ready (sys_ready),
        .sys_rdata (sys_rdata),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Power-up memory pattern
    function automatic logic [31:0] init_word(int word_addr);
        return word_addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [24:0] make_addr(logic [12:0] tag, logic [7:0] index,
                                              logic [1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    function automatic logic [31:0] expected_word(logic [24:0] addr);
        logic [31:0] w;
        int          base;
        base = int'({addr[24:2], 2'b00});
        w    = init_word(int'(addr[24:2]));
        for (int b = 0; b < 4; b++) begin
            if (ref_bytes.exists(base + b)) begin
                w[b*8 +: 8] = ref_bytes[base + b];
            end
        end
        return w;
    endfunction

    function automatic logic [127:0] expected_line(logic [20:0] line_addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = expected_word({line_addr, 2'(w), 2'b00});
        end
        return line;
    endfunction

    task automatic ref_write(logic [24:0] addr, logic [31:0] data, logic [3:0] strb);
        int base;
        base = int'({addr[24:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_bytes[base + b] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic report_mismatch(string test, string what, logic [127:0] expected,
                                   logic [127:0] actual);
        errors++;
        $display("** Error %s: %s expected %0h, actual %0h", test, what, expected, actual);
    endtask

    task automatic end_run();
        $display("Requests: %0d  Mem reads: %0d  Mem writes: %0d  Errors: %0d  Mem faults: %0d",
                 requests, mem_reads, mem_writes, errors, mem_faults);
        if (errors == 0 && mem_faults == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // One full system transaction, entered and left 1 ns after an edge
    task automatic access(logic [24:0] addr, logic [31:0] wdata, logic [3:0] wstrb,
                          output logic [31:0] rdata);
        int cycles;
        sys_req.addr  = addr;
        sys_req.wdata = wdata;
        sys_req.wstrb = wstrb;
        sys_valid     = 1'b1;
        cycles        = 0;
        while (!sys_ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!sys_ready) begin
            errors++;
            $display("Timeout: sys_ready never rose for address %h", addr);
            end_run();
        end else begin
            rdata     = sys_rdata;
            sys_valid = 1'b0;
            cycles    = 0;
            while (sys_ready && cycles < TIMEOUT_CYCLES) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (sys_ready) begin
                errors++;
                $display("Timeout: sys_ready stayed high after sys_valid fell");
                end_run();
            end else begin
                requests++;
                ref_write(addr, wdata, wstrb);
            end
        end
    endtask

    task automatic read_check(string test, logic [24:0] addr);
        logic [31:0] rdata;
        logic [31:0] expected;
        expected = expected_word(addr);
        access(addr, 32'h0, 4'b0000, rdata);
        if (rdata !== expected) begin
            report_mismatch(test, "read data", 128'(expected), 128'(rdata));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model, fixed reply delay
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        logic [`CACHE_MEM_ADDR_BITS-1:0] line_addr;
        int                              base;
        int                              cycles;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_valid && !mem_ready) begin
                line_addr = mem_req.addr;
                base      = int'(line_addr) * 4;
                repeat (MEM_DELAY) @(posedge clk);
                #1;
                for (int w = 0; w < 4; w++) begin
                    if (mem_req.write) begin
                        mem_words[base + w] = mem_req.wdata[w*32 +: 32];
                    end else if (mem_words.exists(base + w)) begin
                        mem_rdata[w*32 +: 32] = mem_words[base + w];
                    end else begin
                        mem_rdata[w*32 +: 32] = init_word(base + w);
                    end
                end
                if (mem_req.write) begin
                    mem_writes++;
                    last_wr_addr = line_addr;
                    last_wr_data = mem_req.wdata;
                end else begin
                    mem_reads++;
                end
                mem_ready = 1'b1;
                cycles    = 0;
                while (mem_valid && cycles < TIMEOUT_CYCLES) begin
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (mem_valid) begin
                    mem_faults++;
                    $display("Memory model: mem_valid stayed high after mem_ready");
                end
                mem_ready = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_read_miss();
        int reads_before;
        reads_before = mem_reads;
        read_check("read_miss", make_addr(13'h0001, 8'd3, 2'd1));
        if (mem_reads != reads_before + 1) begin
            report_mismatch("read_miss", "mem reads", 128'(reads_before + 1), 128'(mem_reads));
        end
    endtask

    task automatic test_repeat_read();
        int reads_before;
        int writes_before;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        read_check("repeat_read", make_addr(13'h0001, 8'd3, 2'd2));
        if (mem_reads != reads_before || mem_writes != writes_before) begin
            report_mismatch("repeat_read", "mem accesses", 128'(reads_before + writes_before),
                            128'(mem_reads + mem_writes));
        end
    endtask

    task automatic test_write_hit();
        logic [24:0] addr;
        logic [31:0] rdata;
        int          writes_before;
        addr          = make_addr(13'h0001, 8'd3, 2'd2);
        writes_before = mem_writes;
        access(addr, 32'hdead_beef, 4'b0101, rdata);
        read_check("write_hit", addr);
        if (mem_writes != writes_before) begin
            report_mismatch("write_hit", "mem writes", 128'(writes_before), 128'(mem_writes));
        end
    endtask

    task automatic test_lru_order();
        logic [24:0] addr_a;
        logic [24:0] addr_b;
        int          reads_before;
        addr_a = make_addr(13'h0020, 8'd10, 2'd0);
        addr_b = make_addr(13'h0021, 8'd10, 2'd3);
        read_check("lru_order", addr_a);
        read_check("lru_order", addr_b);
        // A becomes the newer way, so C must evict B
        read_check("lru_order", addr_a);
        read_check("lru_order", make_addr(13'h0022, 8'd10, 2'd1));
        reads_before = mem_reads;
        read_check("lru_order", addr_a);
        if (mem_reads != reads_before) begin
            report_mismatch("lru_order", "reads after A", 128'(reads_before), 128'(mem_reads));
        end
        read_check("lru_order", addr_b);
        if (mem_reads != reads_before + 1) begin
            report_mismatch("lru_order", "reads after B", 128'(reads_before + 1),
                            128'(mem_reads));
        end
    endtask

    task automatic test_dirty_eviction();
        logic [24:0] addr_d;
        logic [31:0] rdata;
        int          reads_before;
        int          writes_before;
        addr_d        = make_addr(13'h0030, 8'd20, 2'd1);
        reads_before  = mem_reads;
        writes_before = mem_writes;
        // Write miss, then read back the merged word
        access(addr_d, 32'hcafe_f00d, 4'b1110, rdata);
        read_check("dirty_eviction", addr_d);
        if (mem_reads != reads_before + 1 || mem_writes != writes_before) begin
            report_mismatch("dirty_eviction", "write miss accesses", 128'(reads_before + 1),
                            128'(mem_reads));
        end
        read_check("dirty_eviction", make_addr(13'h0031, 8'd20, 2'd0));
        writes_before = mem_writes;
        read_check("dirty_eviction", make_addr(13'h0032, 8'd20, 2'd2));
        if (mem_writes != writes_before + 1) begin
            report_mismatch("dirty_eviction", "mem writes", 128'(writes_before + 1),
                            128'(mem_writes));
        end
        if (last_wr_addr !== {13'h0030, 8'd20}) begin
            report_mismatch("dirty_eviction", "write address", 128'({13'h0030, 8'd20}),
                            128'(last_wr_addr));
        end
        if (last_wr_data !== expected_line({13'h0030, 8'd20})) begin
            report_mismatch("dirty_eviction", "write data", expected_line({13'h0030, 8'd20}),
                            last_wr_data);
        end
        // Clean victim goes without a write
        reads_before  = mem_reads;
        writes_before = mem_writes;
        read_check("dirty_eviction", make_addr(13'h0033, 8'd20, 2'd3));
        if (mem_writes != writes_before || mem_reads != reads_before + 1) begin
            report_mismatch("dirty_eviction", "clean evict writes", 128'(writes_before),
                            128'(mem_writes));
        end
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [24:0] addr;
        logic [31:0] rdata;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r    = next_rand();
            addr = make_addr({10'h020, r[4:2]}, {6'h10, r[1:0]}, r[6:5]);
            if (r[7]) begin
                access(addr, next_rand(), r[11:8], rdata);
            end else begin
                read_check("random_mix", addr);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        sys_valid  = 1'b0;
        sys_req    = '0;
        errors     = 0;
        mem_faults = 0;
        requests   = 0;
        mem_reads  = 0;
        mem_writes = 0;
        rng_state  = 32'h4a7d_3997;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_read_miss();
        test_repeat_read();
        test_write_hit();
        test_lru_order();
        test_dirty_eviction();
        test_random_mix();
        end_run();
    end

endmodule

/* flist.f */
+incdir+design
design/cache_pkg.sv
design/cache_way_ram.sv
design/cache_line_update.sv
design/cache_lookup.sv
design/cache_ctrl.sv
design/ddr_cache.sv
verif/ddr_cache_asserts.sv
verif/ddr_cache_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ddr_cache_tb
FILELIST  = flist.f
BUILD_DIR = obj_dir
PASS_TEXT = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
